// ==== single_bus_datapath.f ====
+incdir+testbench
logic/datapath_pkg.sv
logic/bus_mux.sv
logic/register_file.sv
logic/alu_unit.sv
logic/program_regs.sv
logic/memory_unit.sv
logic/con_ff.sv
logic/datapath.sv
testbench/datapath_tb.sv

// ==== Makefile ====
SIM      = verilator
TOP      = datapath_tb
FILELIST = single_bus_datapath.f
FLAGS    = --binary --timing --assert -Wno-fatal
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
SOURCES  = $(shell grep -v '^+' $(FILELIST)) testbench/datapath_model.svh

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf $(OBJ_DIR)

// ==== testbench/datapath_model.svh ====
`ifndef DATAPATH_MODEL_SVH
`define DATAPATH_MODEL_SVH
`default_nettype none

    datapath_pkg::word_t lfsr_state = 32'h280b;
    datapath_pkg::word_t model_regs [datapath_pkg::REG_COUNT];
    datapath_pkg::word_t model_mem [datapath_pkg::MEM_DEPTH];

    // Fibonacci LFSR with taps 32 22 2 1 and one shift per bit taken
    function automatic datapath_pkg::word_t rand_bits(input int n);
        datapath_pkg::word_t value;
        logic                fb;
        value = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            value = {value[30:0], fb};
        end
        return value;
    endfunction

    function automatic void model_reset();
        for (int i = 0; i < datapath_pkg::REG_COUNT; i++) begin
            model_regs[i] = '0;
        end
    endfunction

    function automatic void model_reg_write(input datapath_pkg::reg_idx_t idx,
                                            input datapath_pkg::word_t value);
        model_regs[idx] = value;
    endfunction

    // R0 reads as zero when the base-address select is on
    function automatic datapath_pkg::word_t model_reg_read(input datapath_pkg::reg_idx_t idx,
                                                           input logic ba);
        if (ba && idx == 4'd0) begin
            return '0;
        end
        return model_regs[idx];
    endfunction

    function automatic void model_mem_write(input logic [8:0] addr,
                                            input datapath_pkg::word_t value);
        model_mem[addr] = value;
    endfunction

    function automatic datapath_pkg::word_t model_mem_read(input logic [8:0] addr);
        return model_mem[addr];
    endfunction

    function automatic datapath_pkg::word_t alu_model(input datapath_pkg::alu_op_t op,
                                                      input datapath_pkg::word_t y,
                                                      input datapath_pkg::word_t b);
        case (op)
            datapath_pkg::alu_add: return y + b;
            datapath_pkg::alu_sub: return y - b;
            datapath_pkg::alu_and: return y & b;
            datapath_pkg::alu_or:  return y | b;
            datapath_pkg::alu_inc: return b + 32'd1;
            default:               return '0;
        endcase
    endfunction

    function automatic logic branch_model(input logic [1:0] c2, input datapath_pkg::word_t b);
        case (c2)
            2'd0:    return b == 32'd0;
            2'd1:    return b != 32'd0;
            2'd2:    return !b[31];
            default: return b[31];
        endcase
    endfunction

    function automatic datapath_pkg::word_t sext_model(input datapath_pkg::word_t ir_word);
        return {{13{ir_word[18]}}, ir_word[18:0]};
    endfunction

    task automatic check_value(input string name, input datapath_pkg::word_t got,
                               input datapath_pkg::word_t expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("[ERROR] %s at %0t ns: got %h, expected %h", name, $time, got, expected);
        end
    endtask

`default_nettype wire
`endif

// ==== testbench/datapath_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module datapath_tb;

    localparam int CLK_PERIOD = 40;
    localparam int N_REG      = 24;
    localparam int N_ALU      = 12;
    localparam int N_MEM      = 16;
    localparam int N_CON      = 24;
    localparam int N_CONST    = 16;
    // Step count of all six tests plus the first reset
    localparam int TOTAL_STEPS = 4 * N_REG + 20 * N_ALU + 7 * N_MEM + 3 * N_CON
                               + 3 * N_CONST + 5 * datapath_pkg::REG_COUNT + 9 + 4;
    localparam int TIMEOUT_NS  = (2 * TOTAL_STEPS + 50) * CLK_PERIOD;

    logic                  clk;
    logic                  rst_n;
    datapath_pkg::drive_t  drive;
    datapath_pkg::load_t   load;
    datapath_pkg::select_t sel;
    datapath_pkg::alu_op_t alu_op;
    logic                  read;
    logic                  mem_write;
    datapath_pkg::word_t   inport_data;
    datapath_pkg::word_t   outport_data;
    logic                  con;

    // Strobes for the next control step
    datapath_pkg::drive_t  nxt_drive;
    datapath_pkg::load_t   nxt_load;
    datapath_pkg::select_t nxt_sel;
    datapath_pkg::alu_op_t nxt_op;
    logic                  nxt_read;
    logic                  nxt_write;
    datapath_pkg::word_t   nxt_in;

    int check_count;
    int error_count;
    int tests_failed;
    int test_checks_start;
    int test_errors_start;

    datapath_pkg::alu_op_t op_list [5];
    logic [8:0]            addr_list [N_MEM];

    datapath #(
        .MEM_DEPTH (datapath_pkg::MEM_DEPTH)
    ) datapath_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .drive        (drive),
        .load         (load),
        .sel          (sel),
        .alu_op       (alu_op),
        .read         (read),
        .mem_write    (mem_write),
        .inport_data  (inport_data),
        .outport_data (outport_data),
        .con          (con)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic clear_next();
        nxt_drive = '0;
        nxt_load  = '0;
        nxt_sel   = '0;
        nxt_op    = datapath_pkg::alu_add;
        nxt_read  = 1'b0;
        nxt_write = 1'b0;
        nxt_in    = '0;
    endtask

    // Values driven here are taken by the DUT at the following edge
    task automatic step();
        @(posedge clk);
        drive       <= nxt_drive;
        load        <= nxt_load;
        sel         <= nxt_sel;
        alu_op      <= nxt_op;
        read        <= nxt_read;
        mem_write   <= nxt_write;
        inport_data <= nxt_in;
        clear_next();
    endtask

    task automatic settle();
        step();
        @(negedge clk);
    endtask

    task automatic load_ir(input datapath_pkg::word_t word);
        nxt_drive.inport_out = 1'b1;
        nxt_load.ir_in = 1'b1;
        nxt_in = word;
        step();
    endtask

    task automatic write_ra(input datapath_pkg::word_t word);
        nxt_drive.inport_out = 1'b1;
        nxt_sel.gra = 1'b1;
        nxt_load.r_in = 1'b1;
        nxt_in = word;
        step();
    endtask

    task automatic read_ra_to_port(input logic ba);
        nxt_drive.r_out = 1'b1;
        nxt_sel.gra = 1'b1;
        nxt_sel.ba_out = ba;
        nxt_load.outport_in = 1'b1;
        step();
    endtask

    task automatic begin_test();
        test_checks_start = check_count;
        test_errors_start = error_count;
    endtask

    task automatic end_test(input string name);
        int errs;
        errs = error_count - test_errors_start;
        $display("%s: %0d checks, %0d errors", name, check_count - test_checks_start, errs);
        if (errs != 0) begin
            tests_failed++;
        end
    endtask

    task automatic test_registers();
        datapath_pkg::word_t    ir_word;
        datapath_pkg::word_t    data;
        datapath_pkg::reg_idx_t ra;
        logic                   ba;
        begin_test();
        for (int i = 0; i < N_REG; i++) begin
            ir_word = rand_bits(32);
            data = rand_bits(32);
            ba = rand_bits(1) != '0;
            // The first two rounds use R0 with and without the base-address select
            if (i < 2) begin
                ir_word[datapath_pkg::RA_MSB:datapath_pkg::RA_LSB] = '0;
                ba = (i == 0);
            end
            ra = ir_word[datapath_pkg::RA_MSB:datapath_pkg::RA_LSB];
            load_ir(ir_word);
            write_ra(data);
            model_reg_write(ra, data);
            read_ra_to_port(ba);
            settle();
            check_value("outport_data", outport_data, model_reg_read(ra, ba));
        end
        end_test("registers");
    endtask

    task automatic test_alu();
        datapath_pkg::word_t a;
        datapath_pkg::word_t b;
        begin_test();
        for (int i = 0; i < N_ALU; i++) begin
            a = rand_bits(32);
            b = rand_bits(32);
            // First pair forces carry out of bit 31
            if (i == 0) begin
                a = '1;
                b = '1;
            end
            for (int k = 0; k < 5; k++) begin
                nxt_drive.inport_out = 1'b1;
                nxt_load.y_in = 1'b1;
                nxt_in = a;
                step();
                nxt_drive.inport_out = 1'b1;
                nxt_load.z_in = 1'b1;
                nxt_op = op_list[k];
                nxt_in = b;
                step();
                nxt_drive.zlow_out = 1'b1;
                nxt_load.outport_in = 1'b1;
                step();
                settle();
                check_value("outport_data", outport_data, alu_model(op_list[k], a, b));
            end
        end
        end_test("alu");
    endtask

    task automatic test_memory();
        datapath_pkg::word_t data;
        logic [8:0]          tmp;
        int                  j;
        begin_test();
        for (int i = 0; i < N_MEM; i++) begin
            addr_list[i] = 9'(rand_bits(9));
            data = rand_bits(32);
            nxt_drive.inport_out = 1'b1;
            nxt_load.mar_in = 1'b1;
            nxt_in = 32'(addr_list[i]);
            step();
            nxt_drive.inport_out = 1'b1;
            nxt_load.mdr_in = 1'b1;
            nxt_in = data;
            step();
            nxt_write = 1'b1;
            step();
            model_mem_write(addr_list[i], data);
        end
        // Fisher-Yates shuffle of the read order
        for (int i = N_MEM - 1; i > 0; i--) begin
            j = int'(rand_bits(8) % (i + 1));
            tmp = addr_list[i];
            addr_list[i] = addr_list[j];
            addr_list[j] = tmp;
        end
        for (int i = 0; i < N_MEM; i++) begin
            nxt_drive.inport_out = 1'b1;
            nxt_load.mar_in = 1'b1;
            nxt_in = 32'(addr_list[i]);
            step();
            nxt_read = 1'b1;
            nxt_load.mdr_in = 1'b1;
            step();
            nxt_drive.mdr_out = 1'b1;
            nxt_load.outport_in = 1'b1;
            step();
            settle();
            check_value("outport_data", outport_data, model_mem_read(addr_list[i]));
        end
        end_test("memory");
    endtask

    task automatic test_branch();
        datapath_pkg::word_t ir_word;
        datapath_pkg::word_t data;
        logic [1:0]          c2;
        begin_test();
        for (int i = 0; i < N_CON; i++) begin
            c2 = 2'(i % 4);
            ir_word = rand_bits(32);
            ir_word[datapath_pkg::C2_MSB:datapath_pkg::C2_LSB] = c2;
            case ((i / 4) % 3)
                0:       data = '0;
                1:       data = rand_bits(32) | 32'h8000_0000;
                default: data = (rand_bits(32) & 32'h7fff_ffff) | 32'h1;
            endcase
            load_ir(ir_word);
            nxt_drive.inport_out = 1'b1;
            nxt_load.con_in = 1'b1;
            nxt_in = data;
            step();
            settle();
            check_value("con", {31'b0, con}, {31'b0, branch_model(c2, data)});
        end
        end_test("branch");
    endtask

    task automatic test_constant();
        datapath_pkg::word_t ir_word;
        begin_test();
        for (int i = 0; i < N_CONST; i++) begin
            ir_word = rand_bits(32);
            load_ir(ir_word);
            nxt_drive.c_out = 1'b1;
            nxt_load.outport_in = 1'b1;
            step();
            settle();
            check_value("outport_data", outport_data, sext_model(ir_word));
        end
        end_test("constant");
    endtask

    task automatic test_reset();
        begin_test();
        for (int r = 0; r < datapath_pkg::REG_COUNT; r++) begin
            load_ir(32'(r) << datapath_pkg::RA_LSB);
            write_ra(rand_bits(32) | 32'h1);
        end
        // cond_nonzero on a nonzero bus sets con
        load_ir(32'h0008_0000);
        nxt_drive.inport_out = 1'b1;
        nxt_load.con_in = 1'b1;
        nxt_load.outport_in = 1'b1;
        nxt_in = 32'h1;
        step();
        settle();
        check_value("con", {31'b0, con}, 32'h1);
        check_value("outport_data", outport_data, 32'h1);
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        model_reset();
        @(negedge clk);
        check_value("con", {31'b0, con}, 32'h0);
        check_value("outport_data", outport_data, 32'h0);
        for (int r = 0; r < datapath_pkg::REG_COUNT; r++) begin
            load_ir(32'(r) << datapath_pkg::RA_LSB);
            read_ra_to_port(1'b0);
            settle();
            check_value("outport_data", outport_data, model_reg_read(4'(r), 1'b0));
        end
        end_test("reset");
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("Watchdog expired after %0d ns with tests still running", TIMEOUT_NS);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        drive = '0;
        load = '0;
        sel = '0;
        alu_op = datapath_pkg::alu_add;
        read = 1'b0;
        mem_write = 1'b0;
        inport_data = '0;
        clear_next();
        model_reset();
        check_count = 0;
        error_count = 0;
        tests_failed = 0;
        op_list[0] = datapath_pkg::alu_add;
        op_list[1] = datapath_pkg::alu_sub;
        op_list[2] = datapath_pkg::alu_and;
        op_list[3] = datapath_pkg::alu_or;
        op_list[4] = datapath_pkg::alu_inc;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        test_registers();
        test_alu();
        test_memory();
        test_branch();
        test_constant();
        test_reset();
        $display("tests: 6, failed: %0d, checks: %0d, errors: %0d",
                 tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

`include "datapath_model.svh"

endmodule

`default_nettype wire

// ==== logic/datapath.sv ====
`timescale 1ns/100ps
`default_nettype none

module datapath #(
    parameter int MEM_DEPTH = datapath_pkg::MEM_DEPTH
) (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire datapath_pkg::drive_t  drive,
    input  wire datapath_pkg::load_t   load,
    input  wire datapath_pkg::select_t sel,
    input  wire datapath_pkg::alu_op_t alu_op,
    input  wire                   read,
    input  wire                   mem_write,
    input  wire datapath_pkg::word_t   inport_data,
    output wire datapath_pkg::word_t   outport_data,
    output wire                   con
);

    wire datapath_pkg::word_t bus;
    wire datapath_pkg::word_t pc;
    wire datapath_pkg::word_t ir;
    wire datapath_pkg::word_t z;
    wire datapath_pkg::word_t mdr;
    wire datapath_pkg::word_t c_sext;
    wire datapath_pkg::word_t reg_data;

    bus_mux bus_mux_i (
        .drive       (drive),
        .pc          (pc),
        .z           (z),
        .mdr         (mdr),
        .c_sext      (c_sext),
        .reg_data    (reg_data),
        .inport_data (inport_data),
        .bus         (bus)
    );

    register_file register_file_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .sel      (sel),
        .ir       (ir),
        .bus      (bus),
        .r_in     (load.r_in),
        .reg_data (reg_data)
    );

    alu_unit alu_unit_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .bus    (bus),
        .alu_op (alu_op),
        .y_in   (load.y_in),
        .z_in   (load.z_in),
        .z      (z)
    );

    program_regs program_regs_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .bus          (bus),
        .pc_in        (load.pc_in),
        .ir_in        (load.ir_in),
        .outport_in   (load.outport_in),
        .pc           (pc),
        .ir           (ir),
        .c_sext       (c_sext),
        .outport_data (outport_data)
    );

    memory_unit #(
        .MEM_DEPTH (MEM_DEPTH)
    ) memory_unit_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus       (bus),
        .mar_in    (load.mar_in),
        .mdr_in    (load.mdr_in),
        .read      (read),
        .mem_write (mem_write),
        .mdr       (mdr)
    );

    con_ff con_ff_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .ir     (ir),
        .bus    (bus),
        .con_in (load.con_in),
        .con    (con)
    );

endmodule

`default_nettype wire

// ==== logic/con_ff.sv ====
`timescale 1ns/100ps
`default_nettype none

module con_ff (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire datapath_pkg::word_t ir,
    input  wire datapath_pkg::word_t bus,
    input  wire                      con_in,
    output logic                     con
);

    datapath_pkg::cond_t cond;
    logic                taken;

    assign cond = datapath_pkg::cond_t'(ir[datapath_pkg::C2_MSB:datapath_pkg::C2_LSB]);

    always_comb begin
        case (cond)
            datapath_pkg::cond_zero:    taken = (bus == '0);
            datapath_pkg::cond_nonzero: taken = (bus != '0);
            datapath_pkg::cond_plus:    taken = !bus[datapath_pkg::WORD_W-1];
            default:                    taken = bus[datapath_pkg::WORD_W-1];
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            con <= 1'b0;
        end else if (con_in) begin
            con <= taken;
        end
    end

endmodule

`default_nettype wire

// ==== logic/memory_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module memory_unit #(
    parameter int MEM_DEPTH = datapath_pkg::MEM_DEPTH
) (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire datapath_pkg::word_t bus,
    input  wire                      mar_in,
    input  wire                      mdr_in,
    input  wire                      read,
    input  wire                      mem_write,
    output datapath_pkg::word_t      mdr
);

    localparam int ADDR_W = $clog2(MEM_DEPTH);

    datapath_pkg::word_t mar;
    datapath_pkg::word_t mem [MEM_DEPTH];
    logic [ADDR_W-1:0]   addr;

    // Upper MAR bits are ignored
    assign addr = mar[ADDR_W-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mar <= '0;
        end else if (mar_in) begin
            mar <= bus;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mdr <= '0;
        end else if (mdr_in) begin
            mdr <= read ? mem[addr] : bus;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_write) begin
            mem[addr] <= mdr;
        end
    end

    a_no_read_write: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(read && mem_write)
    ) else $error("memory_unit: read and mem_write in the same step");

endmodule

`default_nettype wire

// ==== logic/program_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module program_regs (
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire datapath_pkg::word_t bus,
    input  wire                      pc_in,
    input  wire                      ir_in,
    input  wire                      outport_in,
    output datapath_pkg::word_t      pc,
    output datapath_pkg::word_t      ir,
    output datapath_pkg::word_t      c_sext,
    output datapath_pkg::word_t      outport_data
);

    localparam int CONST_W = datapath_pkg::CONST_MSB - datapath_pkg::CONST_LSB + 1;
    localparam int EXT_W   = datapath_pkg::WORD_W - CONST_W;

    // Immediate field widened with its sign bit
    assign c_sext = {{EXT_W{ir[datapath_pkg::CONST_MSB]}},
                     ir[datapath_pkg::CONST_MSB:datapath_pkg::CONST_LSB]};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc           <= '0;
            ir           <= '0;
            outport_data <= '0;
        end else begin
            if (pc_in) begin
                pc <= bus;
            end
            if (ir_in) begin
                ir <= bus;
            end
            if (outport_in) begin
                outport_data <= bus;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/alu_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module alu_unit (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire datapath_pkg::word_t   bus,
    input  wire datapath_pkg::alu_op_t alu_op,
    input  wire                        y_in,
    input  wire                        z_in,
    output datapath_pkg::word_t        z
);

    datapath_pkg::word_t y;
    datapath_pkg::word_t result;

    always_comb begin
        case (alu_op)
            datapath_pkg::alu_add: result = y + bus;
            datapath_pkg::alu_sub: result = y - bus;
            datapath_pkg::alu_and: result = y & bus;
            datapath_pkg::alu_or:  result = y | bus;
            datapath_pkg::alu_inc: result = bus + 1'b1;   // Y is not used here
            default:               result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            y <= '0;
            z <= '0;
        end else begin
            if (y_in) begin
                y <= bus;
            end
            if (z_in) begin
                z <= result;
            end
        end
    end

    a_legal_op: assert property (
        @(posedge clk) disable iff (!rst_n)
        z_in |-> alu_op inside {datapath_pkg::alu_add, datapath_pkg::alu_sub,
                                datapath_pkg::alu_and, datapath_pkg::alu_or,
                                datapath_pkg::alu_inc}
    ) else $error("alu_unit: z_in with unknown ALU operation");

endmodule

`default_nettype wire

// ==== logic/register_file.sv ====
`timescale 1ns/100ps
`default_nettype none

module register_file (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire datapath_pkg::select_t sel,
    input  wire datapath_pkg::word_t   ir,
    input  wire datapath_pkg::word_t   bus,
    input  wire                        r_in,
    output datapath_pkg::word_t        reg_data
);

    datapath_pkg::word_t    regs [datapath_pkg::REG_COUNT];
    datapath_pkg::reg_idx_t idx;

    // Register number comes from the IR field picked by gra/grb/grc
    always_comb begin
        if (sel.gra) begin
            idx = ir[datapath_pkg::RA_MSB:datapath_pkg::RA_LSB];
        end else if (sel.grb) begin
            idx = ir[datapath_pkg::RB_MSB:datapath_pkg::RB_LSB];
        end else if (sel.grc) begin
            idx = ir[datapath_pkg::RC_MSB:datapath_pkg::RC_LSB];
        end else begin
            idx = '0;
        end
    end

    // Base-address reads of R0 see a constant zero
    assign reg_data = (sel.ba_out && idx == '0) ? '0 : regs[idx];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < datapath_pkg::REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (r_in) begin
            regs[idx] <= bus;
        end
    end

    a_write_has_select: assert property (
        @(posedge clk) disable iff (!rst_n)
        r_in |-> $onehot({sel.gra, sel.grb, sel.grc})
    ) else $error("register_file: r_in without exactly one register select");

endmodule

`default_nettype wire

// ==== logic/bus_mux.sv ====
`timescale 1ns/100ps
`default_nettype none

module bus_mux (
    input  wire datapath_pkg::drive_t drive,
    input  wire datapath_pkg::word_t  pc,
    input  wire datapath_pkg::word_t  z,
    input  wire datapath_pkg::word_t  mdr,
    input  wire datapath_pkg::word_t  c_sext,
    input  wire datapath_pkg::word_t  reg_data,
    input  wire datapath_pkg::word_t  inport_data,
    output datapath_pkg::word_t       bus
);

    typedef enum logic [2:0] {
        src_none,
        src_pc,
        src_z,
        src_mdr,
        src_c,
        src_reg,
        src_inport
    } src_t;

    src_t src;

    always_comb begin
        src = src_none;
        if (drive.pc_out)     src = src_pc;
        if (drive.zlow_out)   src = src_z;
        if (drive.mdr_out)    src = src_mdr;
        if (drive.c_out)      src = src_c;
        if (drive.r_out)      src = src_reg;
        if (drive.inport_out) src = src_inport;
    end

    always_comb begin
        case (src)
            src_pc:     bus = pc;
            src_z:      bus = z;
            src_mdr:    bus = mdr;
            src_c:      bus = c_sext;
            src_reg:    bus = reg_data;
            src_inport: bus = inport_data;
            default:    bus = '0;
        endcase
    end

    // Two drivers in one step would be a control error upstream
    always_comb begin
        assert ($onehot0(drive)) else $error("bus_mux: more than one bus source");
    end

endmodule

`default_nettype wire

// ==== logic/datapath_pkg.sv ====
`default_nettype none

package datapath_pkg;

    localparam int WORD_W    = 32;
    localparam int REG_COUNT = 16;
    localparam int MEM_DEPTH = 512;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [3:0]        reg_idx_t;

    // Instruction register fields
    localparam int OPCODE_MSB = 31;
    localparam int OPCODE_LSB = 27;
    localparam int RA_MSB     = 26;
    localparam int RA_LSB     = 23;
    localparam int RB_MSB     = 22;
    localparam int RB_LSB     = 19;
    localparam int RC_MSB     = 18;
    localparam int RC_LSB     = 15;
    localparam int C2_MSB     = 20;
    localparam int C2_LSB     = 19;
    localparam int CONST_MSB  = 18;
    localparam int CONST_LSB  = 0;

    typedef enum logic [4:0] {
        alu_add = 5'd3,
        alu_sub = 5'd4,
        alu_and = 5'd5,
        alu_or  = 5'd6,
        alu_inc = 5'd19
    } alu_op_t;

    typedef enum logic [1:0] {
        cond_zero    = 2'd0,
        cond_nonzero = 2'd1,
        cond_plus    = 2'd2,
        cond_minus   = 2'd3
    } cond_t;

    // One-hot bus sources with the spare bits held low
    typedef struct packed {
        logic [1:0] spare;
        logic       pc_out;
        logic       zlow_out;
        logic       mdr_out;
        logic       c_out;
        logic       r_out;
        logic       inport_out;
    } drive_t;

    typedef struct packed {
        logic pc_in;
        logic ir_in;
        logic y_in;
        logic z_in;
        logic mar_in;
        logic mdr_in;
        logic r_in;
        logic con_in;
        logic outport_in;
    } load_t;

    typedef struct packed {
        logic gra;
        logic grb;
        logic grc;
        logic ba_out;
    } select_t;

endpackage

`default_nettype wire
